// File: src.f
+incdir+include
hdl/ring_pkg.sv
hdl/tile_pkg.sv
hdl/ring_stop.sv
hdl/core_tile.sv
hdl/mem_tile.sv
hdl/ring_top.sv
verification/ring_tb.sv

// File: Makefile
# Verilator build and run of the ring interconnect testbench

VERILATOR ?= verilator
TOP       ?= ringTb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= No errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with Verilator, run it, search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@if grep -q "^$(PASS_TEXT)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/ring_vectors.txt
# columns: test core op(R/W) address(hex) data(hex) expected_rsp_data(hex)
# lines sharing a test name run together, addresses unique within a test
wr_basic     0 W 0010 cafef00d cafef00d
rd_basic_c0  0 R 0010 00000000 cafef00d
rd_basic_c0  0 R 0011 00000000 00000000
rd_basic_c1  1 R 0010 00000000 cafef00d
rd_basic_c1  1 R 003f 00000000 00000000
burst_c0     0 W 0020 11110020 11110020
burst_c0     0 W 0021 11110021 11110021
burst_c0     0 W 0022 11110022 11110022
burst_c0     0 W 0023 11110023 11110023
burst_c1     1 R 0020 00000000 11110020
burst_c1     1 R 0021 00000000 11110021
burst_c1     1 R 0022 00000000 11110022
burst_c1     1 R 0023 00000000 11110023
dual_wr      0 W 0030 a0000030 a0000030
dual_wr      1 W 0035 b1000035 b1000035
dual_wr      0 W 0031 a0000031 a0000031
dual_wr      1 W 0036 b1000036 b1000036
dual_wr      0 W 0032 a0000032 a0000032
dual_wr      1 W 0037 b1000037 b1000037
dual_wr      0 W 0033 a0000033 a0000033
dual_wr      1 W 0038 b1000038 b1000038
dual_wr      0 W 0034 a0000034 a0000034
dual_wr      1 W 0039 b1000039 b1000039
dual_rd      0 R 0035 00000000 b1000035
dual_rd      1 R 0030 00000000 a0000030
dual_rd      0 R 0036 00000000 b1000036
dual_rd      1 R 0031 00000000 a0000031
dual_rd      0 R 0037 00000000 b1000037
dual_rd      1 R 0032 00000000 a0000032
dual_rd      0 R 0038 00000000 b1000038
dual_rd      1 R 0033 00000000 a0000033
dual_rd      0 R 0039 00000000 b1000039
dual_rd      1 R 0034 00000000 a0000034
mix_wr_a     0 W 0004 a4a4a4a4 a4a4a4a4
mix_wr_a     1 W 0005 5b5b5b5b 5b5b5b5b
mix_wr_a     0 W 0006 a6a6a6a6 a6a6a6a6
mix_wr_a     1 W 0007 7b7b7b7b 7b7b7b7b
mix_wr_b     1 W 0004 b4000004 b4000004
mix_wr_b     0 W 0007 a7000007 a7000007
mix_rd       0 R 0004 00000000 b4000004
mix_rd       1 R 0005 00000000 5b5b5b5b
mix_rd       0 R 0006 00000000 a6a6a6a6
mix_rd       1 R 0007 00000000 a7000007

// File: verification/ring_tb.sv
// Ring interconnect testbench

`include "ring_cfg.svh"

module ringTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int    CyclesPerLine = 40;  // a few ring turns plus queue waits
    localparam int    IdleCycles    = 20;
    localparam int    DrainCycles   = 10;  // quiet window, catches stray responses
    localparam string VectorFile    = "verification/ring_vectors.txt";

    logic              QClk;
    logic              RstQnnnH;
    logic              cmdValid   [2];  // index is the core
    ring_pkg::tOpcode  cmdOpcode  [2];
    ring_pkg::tAddress cmdAddress [2];
    ring_pkg::tData    cmdData    [2];
    logic              cmdCredit  [2];
    logic              rspValid   [2];
    ring_pkg::tOpcode  rspOpcode  [2];
    ring_pkg::tAddress rspAddress [2];
    ring_pkg::tData    rspData    [2];

    // vector table, one entry per command
    string             vName [$];
    int                vCore [$];
    ring_pkg::tOpcode  vOp   [$];
    ring_pkg::tAddress vAddr [$];
    ring_pkg::tData    vData [$];
    ring_pkg::tData    vExp  [$];
    bit                vGot  [$];  // response already seen

    int    errCount   = 0;
    int    testCount  = 0;
    int    failCount  = 0;
    int    cycleLimit = 0;
    int    credits      [2];  // host side credit view
    int    creditPulses [2];  // pulses seen in the running test
    int    curFirst;          // vector range of the running test
    int    curLast;
    string curName;

    ringTop DUT (
        .QClk(QClk), .RstQnnnH(RstQnnnH),
        .Cmd0Valid(cmdValid[0]), .Cmd0Opcode(cmdOpcode[0]),
        .Cmd0Address(cmdAddress[0]), .Cmd0Data(cmdData[0]), .Cmd0Credit(cmdCredit[0]),
        .Rsp0Valid(rspValid[0]), .Rsp0Opcode(rspOpcode[0]),
        .Rsp0Address(rspAddress[0]), .Rsp0Data(rspData[0]),
        .Cmd1Valid(cmdValid[1]), .Cmd1Opcode(cmdOpcode[1]),
        .Cmd1Address(cmdAddress[1]), .Cmd1Data(cmdData[1]), .Cmd1Credit(cmdCredit[1]),
        .Rsp1Valid(rspValid[1]), .Rsp1Opcode(rspOpcode[1]),
        .Rsp1Address(rspAddress[1]), .Rsp1Data(rspData[1])
    );

    initial begin
        QClk = 1'b0;
        forever #5 QClk = ~QClk;  // 10 ns period
    end

    // ==================================================
    // vector file reader
    // ==================================================
    task automatic loadVectors();
        int                fd;
        int                n;
        int                core;
        string             line;
        string             name;
        string             opStr;
        ring_pkg::tAddress addr;
        ring_pkg::tData    data;
        ring_pkg::tData    expData;
        fd = $fopen(VectorFile, "r");
        assert (fd != 0) else begin
            $display("cannot open vector file %s", VectorFile);
            errCount++;
        end
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                n = $fgets(line, fd);
                if (line.len() > 1 && line.getc(0) != "#") begin  // skip comments, blanks
                    n = $sscanf(line, "%s %d %s %h %h %h", name, core, opStr, addr, data,
                                expData);
                    assert (n == 6 && (core == 0 || core == 1) &&
                            (opStr == "R" || opStr == "W")) else begin
                        $display("malformed vector line: %s", line);
                        errCount++;
                    end
                    if (n == 6 && (core == 0 || core == 1)) begin
                        vName.push_back(name);
                        vCore.push_back(core);
                        vOp.push_back(opStr == "W" ? ring_pkg::WRITE : ring_pkg::READ);
                        vAddr.push_back(addr);
                        vData.push_back(data);
                        vExp.push_back(expData);
                        vGot.push_back(1'b0);
                    end
                end
            end
            $fclose(fd);
        end
        assert (vName.size() > 0) else begin
            $display("vector file holds no commands");
            errCount++;
        end
    endtask

    // ==================================================
    // response matching, by core and address
    // ==================================================
    task automatic checkResponse(input int core);
        int               hit;
        ring_pkg::tOpcode expOp;
        ring_pkg::tOpcode gotOp;
        hit = -1;
        gotOp = rspOpcode[core];
        for (int i = curFirst; i <= curLast; i++) begin
            if (hit < 0 && vCore[i] == core && vAddr[i] == rspAddress[core] && !vGot[i]) begin
                hit = i;
            end
        end
        // also catches duplicates and responses on the wrong core
        assert (hit >= 0) else begin
            $display("%s: core %0d got a response for address %h it never asked for",
                     curName, core, rspAddress[core]);
            errCount++;
        end
        if (hit >= 0) begin
            vGot[hit] = 1'b1;
            expOp = (vOp[hit] == ring_pkg::WRITE) ? ring_pkg::WRITE_RSP : ring_pkg::READ_RSP;
            assert (gotOp == expOp) else begin
                $display("ERR %s core %0d addr %h opcode: expected %s actual %s",
                         curName, core, vAddr[hit], expOp.name(), gotOp.name());
                errCount++;
            end
            assert (rspData[core] == vExp[hit]) else begin
                $display("ERR %s core %0d addr %h data: expected %h actual %h",
                         curName, core, vAddr[hit], vExp[hit], rspData[core]);
                errCount++;
            end
        end
    endtask

    // outputs sampled mid-cycle, away from the driving edge
    always @(negedge QClk) begin
        if (!RstQnnnH) begin
            for (int c = 0; c < 2; c++) begin
                if (cmdCredit[c]) begin
                    credits[c]++;
                    creditPulses[c]++;
                    assert (credits[c] <= `RING_INJ_CREDITS) else begin
                        $display("%s: core %0d returned more credits than it was given",
                                 curName, c);
                        errCount++;
                    end
                end
                if (rspValid[c]) checkResponse(c);
            end
        end
    end

    task automatic reportTest(input string name, input int errBefore, input int cmds);
        testCount++;
        if (errCount == errBefore) begin
            $display("test %s passed, %0d commands", name, cmds);
        end else begin
            failCount++;
            $display("test %s FAILED, %0d commands, %0d errors", name, cmds,
                     errCount - errBefore);
        end
    endtask

    // ==================================================
    // one test: issue under credits, wait for every response
    // ==================================================
    task automatic runTest(input int first, input int last);
        int nextIdx [2];
        int sent    [2];
        int errBefore;
        bit done;
        errBefore = errCount;
        curName = vName[first];
        curFirst = first;
        curLast = last;
        done = 1'b0;
        for (int c = 0; c < 2; c++) begin
            nextIdx[c] = first;
            sent[c] = 0;
            creditPulses[c] = 0;
        end
        while (!done) begin
            @(posedge QClk);
            for (int c = 0; c < 2; c++) begin
                while (nextIdx[c] <= last && vCore[nextIdx[c]] != c) nextIdx[c]++;
                if (nextIdx[c] <= last && credits[c] > 0) begin
                    cmdValid[c]   <= 1'b1;
                    cmdOpcode[c]  <= vOp[nextIdx[c]];
                    cmdAddress[c] <= vAddr[nextIdx[c]];
                    cmdData[c]    <= vData[nextIdx[c]];
                    credits[c]--;  // spent as the command goes out
                    sent[c]++;
                    nextIdx[c]++;
                end else begin
                    cmdValid[c] <= 1'b0;
                end
            end
            done = 1'b1;
            for (int i = first; i <= last; i++) begin
                if (!vGot[i]) done = 1'b0;
            end
        end
        repeat (DrainCycles) @(posedge QClk);
        for (int c = 0; c < 2; c++) begin
            assert (creditPulses[c] == sent[c]) else begin
                $display("ERR %s core %0d credit pulses: expected %0d actual %0d",
                         curName, c, sent[c], creditPulses[c]);
                errCount++;
            end
        end
        reportTest(curName, errBefore, last - first + 1);
    endtask

    // timeout, limit from the vector count
    initial begin
        int cycles;
        cycles = 0;
        wait (cycleLimit != 0);
        while (cycles < cycleLimit) begin
            @(posedge QClk);
            cycles++;
        end
        $display("timeout: test %s still waiting for responses after %0d cycles",
                 curName, cycles);
        $display("Errors found");
        $finish;
    end

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        int first;
        int last;
        int errBefore;
        RstQnnnH = 1'b1;
        for (int c = 0; c < 2; c++) begin
            cmdValid[c]   = 1'b0;
            cmdOpcode[c]  = ring_pkg::READ;
            cmdAddress[c] = '0;
            cmdData[c]    = '0;
            credits[c]    = `RING_INJ_CREDITS;  // full queue worth after reset
            creditPulses[c] = 0;
        end
        curFirst = 0;
        curLast = -1;  // empty range, any response is unexpected
        curName = "reset";
        loadVectors();
        cycleLimit = vName.size() * CyclesPerLine + IdleCycles +
                     (vName.size() + 1) * DrainCycles + 10;
        repeat (3) @(posedge QClk);
        RstQnnnH <= 1'b0;

        // quiet ring, nothing should come back
        curName = "idle";
        errBefore = errCount;
        repeat (IdleCycles) begin
            @(negedge QClk);
            assert (!rspValid[0] && !rspValid[1] && !cmdCredit[0] && !cmdCredit[1]) else begin
                $display("idle: response or credit seen with no command issued");
                errCount++;
            end
        end
        reportTest("idle", errBefore, 0);

        first = 0;
        while (first < vName.size()) begin
            last = first;
            while (last + 1 < vName.size() && vName[last + 1] == vName[first]) last++;
            runTest(first, last);
            first = last + 1;
        end

        $display("tests %0d, failed %0d, error count %0d", testCount, failCount, errCount);
        if (errCount == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: hdl/ring_top.sv
// Ring interconnect top level

`include "ring_cfg.svh"

module ringTop (
    input  logic              QClk,
    input  logic              RstQnnnH,
    // ==================================================
    // core 0 host ports
    // ==================================================
    input  logic              Cmd0Valid,
    input  ring_pkg::tOpcode  Cmd0Opcode,
    input  ring_pkg::tAddress Cmd0Address,
    input  ring_pkg::tData    Cmd0Data,
    output logic              Cmd0Credit,
    output logic              Rsp0Valid,
    output ring_pkg::tOpcode  Rsp0Opcode,
    output ring_pkg::tAddress Rsp0Address,
    output ring_pkg::tData    Rsp0Data,
    // ==================================================
    // core 1 host ports
    // ==================================================
    input  logic              Cmd1Valid,
    input  ring_pkg::tOpcode  Cmd1Opcode,
    input  ring_pkg::tAddress Cmd1Address,
    input  ring_pkg::tData    Cmd1Data,
    output logic              Cmd1Credit,
    output logic              Rsp1Valid,
    output ring_pkg::tOpcode  Rsp1Opcode,
    output ring_pkg::tAddress Rsp1Address,
    output ring_pkg::tData    Rsp1Data
);

    // slot k feeds tile k, tile k drives slot k+1, mem wraps to slot 0
    logic              ringValid   [`RING_NUM_TILES];
    ring_pkg::tTileId  ringDest    [`RING_NUM_TILES];
    ring_pkg::tTileId  ringSrc     [`RING_NUM_TILES];
    ring_pkg::tOpcode  ringOpcode  [`RING_NUM_TILES];
    ring_pkg::tAddress ringAddress [`RING_NUM_TILES];
    ring_pkg::tData    ringData    [`RING_NUM_TILES];

    coreTile #(.TileId(`RING_CORE0_ID)) uCore0 (
        .QClk(QClk), .RstQnnnH(RstQnnnH),
        .CmdValid(Cmd0Valid), .CmdOpcode(Cmd0Opcode), .CmdAddress(Cmd0Address),
        .CmdData(Cmd0Data), .CmdCredit(Cmd0Credit),
        .RspValid(Rsp0Valid), .RspOpcode(Rsp0Opcode), .RspAddress(Rsp0Address),
        .RspData(Rsp0Data),
        .InValid(ringValid[0]), .InDest(ringDest[0]), .InSrc(ringSrc[0]),
        .InOpcode(ringOpcode[0]), .InAddress(ringAddress[0]), .InData(ringData[0]),
        .OutValid(ringValid[1]), .OutDest(ringDest[1]), .OutSrc(ringSrc[1]),
        .OutOpcode(ringOpcode[1]), .OutAddress(ringAddress[1]), .OutData(ringData[1])
    );

    coreTile #(.TileId(`RING_CORE1_ID)) uCore1 (
        .QClk(QClk), .RstQnnnH(RstQnnnH),
        .CmdValid(Cmd1Valid), .CmdOpcode(Cmd1Opcode), .CmdAddress(Cmd1Address),
        .CmdData(Cmd1Data), .CmdCredit(Cmd1Credit),
        .RspValid(Rsp1Valid), .RspOpcode(Rsp1Opcode), .RspAddress(Rsp1Address),
        .RspData(Rsp1Data),
        .InValid(ringValid[1]), .InDest(ringDest[1]), .InSrc(ringSrc[1]),
        .InOpcode(ringOpcode[1]), .InAddress(ringAddress[1]), .InData(ringData[1]),
        .OutValid(ringValid[2]), .OutDest(ringDest[2]), .OutSrc(ringSrc[2]),
        .OutOpcode(ringOpcode[2]), .OutAddress(ringAddress[2]), .OutData(ringData[2])
    );

    // last stop, closes the loop
    memTile #(.TileId(`RING_MEM_ID)) uMem (
        .QClk(QClk), .RstQnnnH(RstQnnnH),
        .InValid(ringValid[2]), .InDest(ringDest[2]), .InSrc(ringSrc[2]),
        .InOpcode(ringOpcode[2]), .InAddress(ringAddress[2]), .InData(ringData[2]),
        .OutValid(ringValid[0]), .OutDest(ringDest[0]), .OutSrc(ringSrc[0]),
        .OutOpcode(ringOpcode[0]), .OutAddress(ringAddress[0]), .OutData(ringData[0])
    );

endmodule

// File: hdl/mem_tile.sv
// Memory tile

`include "ring_cfg.svh"

module memTile #(
    parameter ring_pkg::tTileId TileId = 4'd3
) (
    input  logic              QClk,
    input  logic              RstQnnnH,
    input  logic              InValid,
    input  ring_pkg::tTileId  InDest,
    input  ring_pkg::tTileId  InSrc,
    input  ring_pkg::tOpcode  InOpcode,
    input  ring_pkg::tAddress InAddress,
    input  ring_pkg::tData    InData,
    output logic              OutValid,
    output ring_pkg::tTileId  OutDest,
    output ring_pkg::tTileId  OutSrc,
    output ring_pkg::tOpcode  OutOpcode,
    output ring_pkg::tAddress OutAddress,
    output ring_pkg::tData    OutData
);

    localparam int IdxW = $clog2(`RING_MEM_FIFO_DEPTH);

    // request fifo
    ring_pkg::tTileId  fSrc     [`RING_MEM_FIFO_DEPTH];
    ring_pkg::tOpcode  fOpcode  [`RING_MEM_FIFO_DEPTH];
    ring_pkg::tAddress fAddress [`RING_MEM_FIFO_DEPTH];
    ring_pkg::tData    fData    [`RING_MEM_FIFO_DEPTH];
    tile_pkg::tQueuePtr    wrPtr, rdPtr;
    tile_pkg::tCreditCount fCount;

    ring_pkg::tData    mem [`RING_MEM_WORDS];
    tile_pkg::tMemState state;

    // request being served
    ring_pkg::tTileId  curSrc;
    ring_pkg::tOpcode  curOpcode, rspOpcode;
    ring_pkg::tAddress curAddress;
    ring_pkg::tData    curData, rspData;

    logic              dlvValid, dlvReady, injTaken;
    logic              push, pop;
    ring_pkg::tTileId  dlvSrc;
    ring_pkg::tOpcode  dlvOpcode;
    ring_pkg::tAddress dlvAddress;
    ring_pkg::tData    dlvData;

    // in SEND a full fifo still accepts, the delivered slot carries our
    // response out and the SM pops in the same cycle
    assign dlvReady = (fCount != tile_pkg::tCreditCount'(`RING_MEM_FIFO_DEPTH)) ||
                      (state == tile_pkg::SEND);
    assign push = dlvValid && dlvReady;
    assign pop  = (fCount != '0) &&
                  ((state == tile_pkg::IDLE) || (state == tile_pkg::SEND && injTaken));

    // ==================================================
    // fifo control and memory controller
    // ==================================================
    always_ff @(posedge QClk or posedge RstQnnnH) begin
        if (RstQnnnH) begin
            wrPtr  <= '0;
            rdPtr  <= '0;
            fCount <= '0;
            state  <= tile_pkg::IDLE;
            for (int i = 0; i < `RING_MEM_WORDS; i++) mem[i] <= '0;
        end else begin
            if (push) wrPtr <= (wrPtr == tile_pkg::tQueuePtr'(`RING_MEM_FIFO_DEPTH - 1)) ?
                               '0 : wrPtr + 1'b1;
            if (pop)  rdPtr <= (rdPtr == tile_pkg::tQueuePtr'(`RING_MEM_FIFO_DEPTH - 1)) ?
                               '0 : rdPtr + 1'b1;
            if (push && !pop) fCount <= fCount + 1'b1;
            else if (!push && pop) fCount <= fCount - 1'b1;
            case (state)
                tile_pkg::IDLE:   if (pop) state <= tile_pkg::ACCESS;
                tile_pkg::ACCESS: begin
                    if (curOpcode == ring_pkg::WRITE)
                        mem[tile_pkg::tMemIndex'(curAddress)] <= curData;
                    state <= tile_pkg::SEND;
                end
                tile_pkg::SEND:   if (injTaken) state <= pop ? tile_pkg::ACCESS : tile_pkg::IDLE;
                default:          state <= tile_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge QClk) begin
        if (push) begin
            fSrc[wrPtr[IdxW-1:0]]     <= dlvSrc;
            fOpcode[wrPtr[IdxW-1:0]]  <= dlvOpcode;
            fAddress[wrPtr[IdxW-1:0]] <= dlvAddress;
            fData[wrPtr[IdxW-1:0]]    <= dlvData;
        end
        if (pop) begin  // load fifo head
            curSrc     <= fSrc[rdPtr[IdxW-1:0]];
            curOpcode  <= fOpcode[rdPtr[IdxW-1:0]];
            curAddress <= fAddress[rdPtr[IdxW-1:0]];
            curData    <= fData[rdPtr[IdxW-1:0]];
        end
        if (state == tile_pkg::ACCESS) begin  // response ready next cycle
            if (curOpcode == ring_pkg::WRITE) begin
                rspOpcode <= ring_pkg::WRITE_RSP;
                rspData   <= curData;
            end else begin
                rspOpcode <= ring_pkg::READ_RSP;
                rspData   <= mem[tile_pkg::tMemIndex'(curAddress)];
            end
        end
    end

    ringStop #(.TileId(TileId)) uStop (
        .QClk(QClk), .RstQnnnH(RstQnnnH),
        .InValid(InValid), .InDest(InDest), .InSrc(InSrc),
        .InOpcode(InOpcode), .InAddress(InAddress), .InData(InData),
        .OutValid(OutValid), .OutDest(OutDest), .OutSrc(OutSrc),
        .OutOpcode(OutOpcode), .OutAddress(OutAddress), .OutData(OutData),
        .DeliverValid(dlvValid), .DeliverSrc(dlvSrc), .DeliverOpcode(dlvOpcode),
        .DeliverAddress(dlvAddress), .DeliverData(dlvData), .DeliverReady(dlvReady),
        .InjectValid(state == tile_pkg::SEND),
        .InjectDest(curSrc),  // back to the requester
        .InjectOpcode(rspOpcode), .InjectAddress(curAddress), .InjectData(rspData),
        .InjectTaken(injTaken)
    );

endmodule

// File: hdl/core_tile.sv
// Core tile with credited command port

`include "ring_cfg.svh"

module coreTile #(
    parameter ring_pkg::tTileId TileId = 4'd1
) (
    input  logic              QClk,
    input  logic              RstQnnnH,
    // host command port
    input  logic              CmdValid,
    input  ring_pkg::tOpcode  CmdOpcode,   // READ or WRITE only
    input  ring_pkg::tAddress CmdAddress,
    input  ring_pkg::tData    CmdData,
    output logic              CmdCredit,   // one pulse per credit back
    // host response port, always accepted
    output logic              RspValid,
    output ring_pkg::tOpcode  RspOpcode,
    output ring_pkg::tAddress RspAddress,
    output ring_pkg::tData    RspData,
    // ring side
    input  logic              InValid,
    input  ring_pkg::tTileId  InDest,
    input  ring_pkg::tTileId  InSrc,
    input  ring_pkg::tOpcode  InOpcode,
    input  ring_pkg::tAddress InAddress,
    input  ring_pkg::tData    InData,
    output logic              OutValid,
    output ring_pkg::tTileId  OutDest,
    output ring_pkg::tTileId  OutSrc,
    output ring_pkg::tOpcode  OutOpcode,
    output ring_pkg::tAddress OutAddress,
    output ring_pkg::tData    OutData
);

    localparam int IdxW = $clog2(`RING_INJ_CREDITS);

    // command queue storage
    ring_pkg::tOpcode  qOpcode  [`RING_INJ_CREDITS];
    ring_pkg::tAddress qAddress [`RING_INJ_CREDITS];
    ring_pkg::tData    qData    [`RING_INJ_CREDITS];

    tile_pkg::tQueuePtr    wrPtr;
    tile_pkg::tQueuePtr    rdPtr;
    tile_pkg::tCreditCount qCount;

    logic              injTaken;
    logic              dlvValid;
    ring_pkg::tOpcode  dlvOpcode;
    ring_pkg::tAddress dlvAddress;
    ring_pkg::tData    dlvData;

    // ==================================================
    // command queue, credits keep it from overflowing
    // ==================================================
    always_ff @(posedge QClk or posedge RstQnnnH) begin
        if (RstQnnnH) begin
            wrPtr     <= '0;
            rdPtr     <= '0;
            qCount    <= '0;
            CmdCredit <= 1'b0;
        end else begin
            CmdCredit <= injTaken;  // pop returns the credit
            if (CmdValid) begin
                wrPtr <= (wrPtr == tile_pkg::tQueuePtr'(`RING_INJ_CREDITS - 1)) ?
                         '0 : wrPtr + 1'b1;
            end
            if (injTaken) begin
                rdPtr <= (rdPtr == tile_pkg::tQueuePtr'(`RING_INJ_CREDITS - 1)) ?
                         '0 : rdPtr + 1'b1;
            end
            if (CmdValid && !injTaken) qCount <= qCount + 1'b1;
            else if (!CmdValid && injTaken) qCount <= qCount - 1'b1;
        end
    end

    always_ff @(posedge QClk) begin
        if (CmdValid) begin
            qOpcode[wrPtr[IdxW-1:0]]  <= CmdOpcode;
            qAddress[wrPtr[IdxW-1:0]] <= CmdAddress;
            qData[wrPtr[IdxW-1:0]]    <= CmdData;
        end
    end

    // ==================================================
    // response path, registered to host
    // ==================================================
    always_ff @(posedge QClk or posedge RstQnnnH) begin
        if (RstQnnnH) RspValid <= 1'b0;
        else          RspValid <= dlvValid;
    end

    always_ff @(posedge QClk) begin
        if (dlvValid) begin
            RspOpcode  <= dlvOpcode;
            RspAddress <= dlvAddress;
            RspData    <= dlvData;
        end
    end

    ringStop #(.TileId(TileId)) uStop (
        .QClk(QClk), .RstQnnnH(RstQnnnH),
        .InValid(InValid), .InDest(InDest), .InSrc(InSrc),
        .InOpcode(InOpcode), .InAddress(InAddress), .InData(InData),
        .OutValid(OutValid), .OutDest(OutDest), .OutSrc(OutSrc),
        .OutOpcode(OutOpcode), .OutAddress(OutAddress), .OutData(OutData),
        .DeliverValid(dlvValid), .DeliverSrc(), .DeliverOpcode(dlvOpcode),
        .DeliverAddress(dlvAddress), .DeliverData(dlvData),
        .DeliverReady(1'b1),                                  // responses always sink here
        .InjectValid(qCount != '0),                           // head of queue
        .InjectDest(ring_pkg::tTileId'(`RING_MEM_ID)),
        .InjectOpcode(qOpcode[rdPtr[IdxW-1:0]]),
        .InjectAddress(qAddress[rdPtr[IdxW-1:0]]),
        .InjectData(qData[rdPtr[IdxW-1:0]]),
        .InjectTaken(injTaken)
    );

endmodule

// File: hdl/ring_stop.sv
// Registered ring stop

module ringStop #(
    parameter ring_pkg::tTileId TileId = 4'd1
) (
    input  logic              QClk,
    input  logic              RstQnnnH,
    // ==================================================
    // ring in, from previous stop
    // ==================================================
    input  logic              InValid,
    input  ring_pkg::tTileId  InDest,
    input  ring_pkg::tTileId  InSrc,
    input  ring_pkg::tOpcode  InOpcode,
    input  ring_pkg::tAddress InAddress,
    input  ring_pkg::tData    InData,
    // ring out, registered hop to next stop
    output logic              OutValid,
    output ring_pkg::tTileId  OutDest,
    output ring_pkg::tTileId  OutSrc,
    output ring_pkg::tOpcode  OutOpcode,
    output ring_pkg::tAddress OutAddress,
    output ring_pkg::tData    OutData,
    // ==================================================
    // tile side
    // ==================================================
    output logic              DeliverValid,  // slot addressed to this tile
    output ring_pkg::tTileId  DeliverSrc,
    output ring_pkg::tOpcode  DeliverOpcode,
    output ring_pkg::tAddress DeliverAddress,
    output ring_pkg::tData    DeliverData,
    input  logic              DeliverReady,  // tile sinks it this cycle
    input  logic              InjectValid,
    input  ring_pkg::tTileId  InjectDest,
    input  ring_pkg::tOpcode  InjectOpcode,
    input  ring_pkg::tAddress InjectAddress,
    input  ring_pkg::tData    InjectData,
    output logic              InjectTaken    // local msg won the slot
);

    logic forMe;      // incoming slot is ours
    logic delivered;  // and the tile takes it
    logic passThru;   // slot keeps travelling
    logic slotFree;   // nothing passing, inject allowed

    assign forMe     = InValid && (InDest == TileId);
    assign delivered = forMe && DeliverReady;
    assign passThru  = InValid && !delivered;  // refused msgs go round again
    assign slotFree  = !passThru;

    // offer straight from the incoming slot
    assign DeliverValid   = forMe;
    assign DeliverSrc     = InSrc;
    assign DeliverOpcode  = InOpcode;
    assign DeliverAddress = InAddress;
    assign DeliverData    = InData;

    // passing traffic always wins
    assign InjectTaken = InjectValid && slotFree;

    // ==================================================
    // outgoing slot
    // ==================================================
    always_ff @(posedge QClk or posedge RstQnnnH) begin
        if (RstQnnnH) begin
            OutValid <= 1'b0;
        end else begin
            OutValid <= passThru || InjectTaken;
        end
    end

    always_ff @(posedge QClk) begin
        if (passThru) begin
            OutDest    <= InDest;    // forward unchanged
            OutSrc     <= InSrc;
            OutOpcode  <= InOpcode;
            OutAddress <= InAddress;
            OutData    <= InData;
        end else if (InjectTaken) begin
            OutDest    <= InjectDest;
            OutSrc     <= TileId;    // stamp sender
            OutOpcode  <= InjectOpcode;
            OutAddress <= InjectAddress;
            OutData    <= InjectData;
        end
    end

endmodule

// File: hdl/tile_pkg.sv
// Tile internal types

`include "ring_cfg.svh"

package tile_pkg;

    // index into the mem tile word array
    typedef logic [$clog2(`RING_MEM_WORDS)-1:0] tMemIndex;

    typedef logic [2:0] tQueuePtr;     // rd / wr pointers, wrap at depth
    typedef logic [2:0] tCreditCount;  // occupancy, 0..depth inclusive

    // mem tile controller
    typedef enum logic [1:0] {
        IDLE,    // waiting on request fifo
        ACCESS,  // array read or write
        SEND     // response offered to ring stop
    } tMemState;

endpackage

// File: hdl/ring_pkg.sv
// Ring message format

package ring_pkg;

    // ==================================================
    // opcodes carried in every slot
    // ==================================================
    typedef enum logic [1:0] {
        READ      = 2'b00,  // core -> mem
        WRITE     = 2'b01,  // core -> mem
        READ_RSP  = 2'b10,  // mem -> core, stored word
        WRITE_RSP = 2'b11   // mem -> core, echo of write
    } tOpcode;

    // ==================================================
    // message fields
    // ==================================================
    typedef logic [3:0]  tTileId;   // Dest / Src on the ring
    typedef logic [15:0] tAddress;  // word address
    typedef logic [31:0] tData;     // one data word

endpackage

// File: include/ring_cfg.svh
// Ring interconnect configuration

`ifndef RING_CFG_SVH
`define RING_CFG_SVH

// ==================================================
// ring population
// ==================================================
`define RING_NUM_TILES      3   // stops on the loop
`define RING_CORE0_ID       1
`define RING_CORE1_ID       2
`define RING_MEM_ID         3

// ==================================================
// queues and storage
// ==================================================
`define RING_INJ_CREDITS    4   // core cmd queue depth, host credits
`define RING_MEM_FIFO_DEPTH 2   // kept tiny so requests recirculate
`define RING_MEM_WORDS      64

`endif
